// ==== sources.f ====
rtl/dsi_regs_pkg.sv
rtl/reg_bus_if.sv
rtl/avalon_mm_slave.sv
rtl/dsi_ctrl_regs.sv
rtl/dsi_irq_ctrl.sv
rtl/dsi_regs_top.sv
testbench/tb_dsi_regs.sv

// ==== Bender.yml ====
package:
  name: dsi_regs

sources:
  - files:
      - rtl/dsi_regs_pkg.sv
      - rtl/reg_bus_if.sv
      - rtl/avalon_mm_slave.sv
      - rtl/dsi_ctrl_regs.sv
      - rtl/dsi_irq_ctrl.sv
      - rtl/dsi_regs_top.sv
  - target: test
    files:
      - testbench/tb_dsi_regs.sv

// ==== testbench/tb_dsi_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_dsi_regs
    import dsi_regs_pkg::*;
();

    localparam int DLY         = 2;    // drive and sample point after the rising edge.
    localparam int BUS_TIMEOUT = 20;
    localparam int IRQ_TIMEOUT = 10;

    logic                     clk;
    logic                     rst_n;
    logic                     irq;
    logic [ADDR_WIDTH-1:0]    avl_mm_addr;
    logic                     avl_mm_read;
    logic                     avl_mm_write;
    logic [DATA_WIDTH-1:0]    avl_mm_writedata;
    logic [DATA_WIDTH-1:0]    avl_mm_readdata;
    avl_resp_e                avl_mm_response;
    logic                     avl_mm_waitrequest;
    logic                     packet_assembler_enable;
    logic                     lanes_enable;
    logic                     clk_out_enable;
    logic                     send_cmd;
    logic [CR_LANES_WIDTH:0]  lanes_number;
    logic [CMD_WIDTH-1:0]     cmd_packet;
    logic [TIMEOUT_WIDTH-1:0] tlpx_timeout;
    logic [TIMEOUT_WIDTH-1:0] hs_prepare_timeout;
    logic [TIMEOUT_WIDTH-1:0] hs_exit_timeout;
    logic [TIMEOUT_WIDTH-1:0] hs_go_timeout;
    logic [TIMEOUT_WIDTH-1:0] hs_trail_timeout;
    logic                     pix_buffer_underflow_set;
    logic                     lanes_ready_set;
    logic                     clk_ready_set;
    logic                     lanes_active;

    // model of the register file, indexed by offset / 4.
    logic [DATA_WIDTH-1:0] model [6];
    int                    wr_idx [5] = '{0, 2, 3, 4, 5};   // ISR is excluded from random writes.
    logic [DATA_WIDTH-1:0] rd;
    logic [1:0]            resp;

    dsi_regs_top dut (.*);

    always #10 clk = ~clk;

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
        if (actual !== expected)
            stop_on_error($sformatf("CHECK FAILED: %s is 0x%08h, expected 0x%08h",
                                    name, actual, expected));
    endtask

    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk);
            #DLY;
        end
    endtask

    // one Avalon transfer; returns at the sample point of the cycle with waitrequest low.
    task automatic bus_transfer(input logic [ADDR_WIDTH-1:0] addr, input logic is_write,
                                input logic [31:0] data, output logic [31:0] rdata,
                                output logic [1:0] rsp);
        int cycles;
        cycles           = 0;
        avl_mm_addr      = addr;
        avl_mm_write     = is_write;
        avl_mm_read      = !is_write;
        avl_mm_writedata = data;
        step(1);
        while (avl_mm_waitrequest) begin
            if (cycles == BUS_TIMEOUT)
                stop_on_error($sformatf("timeout: no waitrequest low at address 0x%02h", addr));
            step(1);
            cycles++;
        end
        rdata        = avl_mm_readdata;
        rsp          = avl_mm_response;
        avl_mm_read  = 1'b0;
        avl_mm_write = 1'b0;
    endtask

    task automatic avl_write(input logic [ADDR_WIDTH-1:0] addr, input logic [31:0] data,
                             input logic [1:0] exp_resp);
        logic [31:0] unused;
        bus_transfer(addr, 1'b1, data, unused, resp);
        check_eq("avl_mm_response", resp, exp_resp);
    endtask

    task automatic avl_read(input logic [ADDR_WIDTH-1:0] addr, output logic [31:0] data,
                            input logic [1:0] exp_resp);
        bus_transfer(addr, 1'b0, '0, data, resp);
        check_eq("avl_mm_response", resp, exp_resp);
    endtask

    // applies the field rules of each register to a host write.
    task automatic model_write(input int idx, input logic [31:0] data);
        case (idx)
            0: model[0] = data & 32'h0000_030F;
            1: model[1] = model[1] & ~(data & 32'h1F);   // write one to clear.
            2: model[2] = data & 32'h0000_001F;
            3: model[3] = data & 32'h00FF_FFFF;
            4: model[4] = data & 32'h0000_FFFF;
            default: model[5] = data & 32'h00FF_FFFF;
        endcase
    endtask

    function automatic logic [31:0] ref_read(input int idx);
        return model[idx];
    endfunction

    task automatic check_ports();
        check_eq("packet_assembler_enable", packet_assembler_enable, model[0][0]);
        check_eq("lanes_enable", lanes_enable, model[0][1]);
        check_eq("clk_out_enable", clk_out_enable, model[0][2]);
        check_eq("send_cmd", send_cmd, model[0][3]);
        check_eq("lanes_number", lanes_number, model[0][9:8] + 3'd1);
        check_eq("tlpx_timeout", tlpx_timeout, model[3][23:16]);
        check_eq("hs_prepare_timeout", hs_prepare_timeout, model[3][15:8]);
        check_eq("hs_exit_timeout", hs_exit_timeout, model[3][7:0]);
        check_eq("hs_go_timeout", hs_go_timeout, model[4][15:8]);
        check_eq("hs_trail_timeout", hs_trail_timeout, model[4][7:0]);
        check_eq("cmd_packet", cmd_packet, model[5][23:0]);
    endtask

    task automatic check_all_regs();
        logic [31:0] data;
        for (int i = 0; i < 6; i++) begin
            avl_read(i * 4, data, RESP_OKAY);
            check_eq($sformatf("avl_mm_readdata at 0x%02h", i * 4), data, ref_read(i));
        end
    endtask

    task automatic wait_irq(input logic expected);
        int cycles;
        cycles = 0;
        while (irq !== expected) begin
            if (cycles == IRQ_TIMEOUT)
                stop_on_error($sformatf("timeout: irq did not settle to %0b", expected));
            step(1);
            cycles++;
        end
    endtask

    task automatic pulse_event(input int ev);
        pix_buffer_underflow_set = (ev == 0);
        lanes_ready_set          = (ev == 1);
        clk_ready_set            = (ev == 2);
        step(1);
        pix_buffer_underflow_set = 1'b0;
        lanes_ready_set          = 1'b0;
        clk_ready_set            = 1'b0;
        model[1][ev] = 1'b1;
    endtask

    task automatic set_lanes_active(input logic value);
        if (value && !lanes_active) begin
            model[1][3] = 1'b1;
            model[0][3] = 1'b0;   // the pending command is taken.
        end else if (!value && lanes_active) begin
            model[1][4] = 1'b1;
        end
        lanes_active = value;
        step(1);
    endtask

    initial begin
        void'($urandom(32'h406));
        clk                      = 1'b0;
        rst_n                    = 1'b0;
        avl_mm_addr              = '0;
        avl_mm_read              = 1'b0;
        avl_mm_write             = 1'b0;
        avl_mm_writedata         = '0;
        pix_buffer_underflow_set = 1'b0;
        lanes_ready_set          = 1'b0;
        clk_ready_set            = 1'b0;
        lanes_active             = 1'b0;
        model = '{32'h300, 32'h0, 32'h0, 32'h0008_0F03, 32'h1E02, 32'h0};
        repeat (5) @(posedge clk);
        #DLY;
        rst_n = 1'b1;
        step(1);

        check_eq("avl_mm_waitrequest", avl_mm_waitrequest, 1'b1);
        check_eq("irq", irq, 1'b0);
        check_ports();
        check_all_regs();

        for (int n = 0; n < 40; n++) begin
            int          idx;
            logic [31:0] data;
            idx  = wr_idx[$urandom % 5];
            data = $urandom;
            avl_write(idx * 4, data, RESP_OKAY);
            model_write(idx, data);
            check_ports();
            avl_read(idx * 4, rd, RESP_OKAY);
            check_eq($sformatf("avl_mm_readdata at 0x%02h", idx * 4), rd, ref_read(idx));
        end

        avl_write(REG_CR_OFFSET, 32'h0000_020D, RESP_OKAY);
        model_write(0, 32'h0000_020D);
        check_eq("send_cmd", send_cmd, 1'b1);
        set_lanes_active(1'b1);
        check_eq("send_cmd", send_cmd, 1'b0);
        avl_read(REG_CR_OFFSET, rd, RESP_OKAY);
        check_eq("avl_mm_readdata at 0x00", rd, ref_read(0));
        set_lanes_active(1'b0);

        // every event source, then a partial clear.
        for (int ev = 0; ev < 3; ev++) pulse_event(ev);
        check_all_regs();
        avl_write(REG_ISR_OFFSET, 32'h0A, RESP_OKAY);
        model_write(1, 32'h0A);
        check_all_regs();

        for (int n = 0; n < 8; n++) begin
            logic [31:0] data;
            data = $urandom;
            avl_write(REG_IER_OFFSET, data, RESP_OKAY);
            model_write(2, data);
            wait_irq(|(model[1] & model[2]));
        end
        avl_write(REG_IER_OFFSET, 32'h02, RESP_OKAY);
        model_write(2, 32'h02);
        avl_write(REG_ISR_OFFSET, 32'h1F, RESP_OKAY);
        model_write(1, 32'h1F);
        wait_irq(1'b0);
        pulse_event(1);
        wait_irq(1'b1);

        for (int a = 'h18; a < 'h20; a++) begin
            avl_write(a, $urandom, RESP_SLVERR);
            avl_read(a, rd, RESP_SLVERR);
            check_eq("avl_mm_readdata", rd, 32'h0);
        end
        check_all_regs();
        check_ports();

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/dsi_regs_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module dsi_regs_top
    import dsi_regs_pkg::*;
#(
    parameter logic [TIMEOUT_WIDTH-1:0]  TLPX_RESET       = 8'd8,
    parameter logic [TIMEOUT_WIDTH-1:0]  HS_PREPARE_RESET = 8'd15,
    parameter logic [TIMEOUT_WIDTH-1:0]  HS_EXIT_RESET    = 8'd3,
    parameter logic [TIMEOUT_WIDTH-1:0]  HS_GO_RESET      = 8'd30,
    parameter logic [TIMEOUT_WIDTH-1:0]  HS_TRAIL_RESET   = 8'd2,
    parameter logic [CR_LANES_WIDTH-1:0] LANES_RESET      = 2'd3
) (
    input  logic                     clk,
    input  logic                     rst_n,
    output logic                     irq,
    input  logic [ADDR_WIDTH-1:0]    avl_mm_addr,
    input  logic                     avl_mm_read,
    input  logic                     avl_mm_write,
    input  logic [DATA_WIDTH-1:0]    avl_mm_writedata,
    output logic [DATA_WIDTH-1:0]    avl_mm_readdata,
    output avl_resp_e                avl_mm_response,
    output logic                     avl_mm_waitrequest,
    output logic                     packet_assembler_enable,
    output logic                     lanes_enable,
    output logic                     clk_out_enable,
    output logic                     send_cmd,
    output logic [CR_LANES_WIDTH:0]  lanes_number,
    output logic [CMD_WIDTH-1:0]     cmd_packet,
    output logic [TIMEOUT_WIDTH-1:0] tlpx_timeout,
    output logic [TIMEOUT_WIDTH-1:0] hs_prepare_timeout,
    output logic [TIMEOUT_WIDTH-1:0] hs_exit_timeout,
    output logic [TIMEOUT_WIDTH-1:0] hs_go_timeout,
    output logic [TIMEOUT_WIDTH-1:0] hs_trail_timeout,
    input  logic                     pix_buffer_underflow_set,
    input  logic                     lanes_ready_set,
    input  logic                     clk_ready_set,
    input  logic                     lanes_active
);

    logic [IRQ_EVENTS-1:0] ier;
    logic [IRQ_EVENTS-1:0] isr;
    logic [IRQ_EVENTS-1:0] isr_clear;

    reg_bus_if bus ();

    avalon_mm_slave u_avalon_mm_slave (
        .clk         (clk),
        .rst_n       (rst_n),
        .addr        (avl_mm_addr),
        .read        (avl_mm_read),
        .write       (avl_mm_write),
        .writedata   (avl_mm_writedata),
        .readdata    (avl_mm_readdata),
        .response    (avl_mm_response),
        .waitrequest (avl_mm_waitrequest),
        .bus         (bus.master)
    );

    dsi_ctrl_regs #(
        .TLPX_RESET       (TLPX_RESET),
        .HS_PREPARE_RESET (HS_PREPARE_RESET),
        .HS_EXIT_RESET    (HS_EXIT_RESET),
        .HS_GO_RESET      (HS_GO_RESET),
        .HS_TRAIL_RESET   (HS_TRAIL_RESET),
        .LANES_RESET      (LANES_RESET)
    ) u_dsi_ctrl_regs (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .lanes_active            (lanes_active),
        .isr                     (isr),
        .bus                     (bus.slave),
        .ier                     (ier),
        .isr_clear               (isr_clear),
        .packet_assembler_enable (packet_assembler_enable),
        .lanes_enable            (lanes_enable),
        .clk_out_enable          (clk_out_enable),
        .send_cmd                (send_cmd),
        .lanes_number            (lanes_number),
        .cmd_packet              (cmd_packet),
        .tlpx_timeout            (tlpx_timeout),
        .hs_prepare_timeout      (hs_prepare_timeout),
        .hs_exit_timeout         (hs_exit_timeout),
        .hs_go_timeout           (hs_go_timeout),
        .hs_trail_timeout        (hs_trail_timeout)
    );

    dsi_irq_ctrl u_dsi_irq_ctrl (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .pix_buffer_underflow_set (pix_buffer_underflow_set),
        .lanes_ready_set          (lanes_ready_set),
        .clk_ready_set            (clk_ready_set),
        .lanes_active             (lanes_active),
        .ier                      (ier),
        .isr_clear                (isr_clear),
        .isr                      (isr),
        .irq                      (irq)
    );

endmodule

`default_nettype wire

// ==== rtl/dsi_irq_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module dsi_irq_ctrl
    import dsi_regs_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pix_buffer_underflow_set,
    input  logic                  lanes_ready_set,
    input  logic                  clk_ready_set,
    input  logic                  lanes_active,
    input  logic [IRQ_EVENTS-1:0] ier,
    input  logic [IRQ_EVENTS-1:0] isr_clear,
    output logic [IRQ_EVENTS-1:0] isr,
    output logic                  irq
);

    logic                  lanes_active_q;
    logic [IRQ_EVENTS-1:0] set_vec;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lanes_active_q <= 1'b0;
        end else begin
            lanes_active_q <= lanes_active;
        end
    end

    always_comb begin
        set_vec                    = '0;
        set_vec[EV_PIX_UNDERFLOW]  = pix_buffer_underflow_set;
        set_vec[EV_LANES_READY]    = lanes_ready_set;
        set_vec[EV_CLK_READY]      = clk_ready_set;
        set_vec[EV_LANES_ACTIVE]   = lanes_active & ~lanes_active_q;   // rising edge.
        set_vec[EV_LANES_INACTIVE] = ~lanes_active & lanes_active_q;   // falling edge.
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            isr <= '0;
            irq <= 1'b0;
        end else begin
            // a clear from the host overrides an event in the same cycle.
            isr <= (isr | set_vec) & ~isr_clear;
            irq <= |(isr & ier);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/dsi_ctrl_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module dsi_ctrl_regs
    import dsi_regs_pkg::*;
#(
    parameter logic [TIMEOUT_WIDTH-1:0]  TLPX_RESET       = 8'd8,
    parameter logic [TIMEOUT_WIDTH-1:0]  HS_PREPARE_RESET = 8'd15,
    parameter logic [TIMEOUT_WIDTH-1:0]  HS_EXIT_RESET    = 8'd3,
    parameter logic [TIMEOUT_WIDTH-1:0]  HS_GO_RESET      = 8'd30,
    parameter logic [TIMEOUT_WIDTH-1:0]  HS_TRAIL_RESET   = 8'd2,
    parameter logic [CR_LANES_WIDTH-1:0] LANES_RESET      = 2'd3
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     lanes_active,
    input  logic [IRQ_EVENTS-1:0]    isr,
    reg_bus_if.slave                 bus,
    output logic [IRQ_EVENTS-1:0]    ier,
    output logic [IRQ_EVENTS-1:0]    isr_clear,
    output logic                     packet_assembler_enable,
    output logic                     lanes_enable,
    output logic                     clk_out_enable,
    output logic                     send_cmd,
    output logic [CR_LANES_WIDTH:0]  lanes_number,
    output logic [CMD_WIDTH-1:0]     cmd_packet,
    output logic [TIMEOUT_WIDTH-1:0] tlpx_timeout,
    output logic [TIMEOUT_WIDTH-1:0] hs_prepare_timeout,
    output logic [TIMEOUT_WIDTH-1:0] hs_exit_timeout,
    output logic [TIMEOUT_WIDTH-1:0] hs_go_timeout,
    output logic [TIMEOUT_WIDTH-1:0] hs_trail_timeout
);

    logic                      access;
    logic                      wr_en;
    logic [CR_LANES_WIDTH-1:0] cr_lanes;
    logic [DATA_WIDTH-1:0]     rd_mux;

    assign access = bus.req && !bus.ack;   // first cycle of a request.
    assign wr_en  = access && bus.write;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= bus.req;   // follows req one cycle later in both directions.
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            packet_assembler_enable <= 1'b0;
            lanes_enable            <= 1'b0;
            clk_out_enable          <= 1'b0;
            send_cmd                <= 1'b0;
            cr_lanes                <= LANES_RESET;
            ier                     <= '0;
            tlpx_timeout            <= TLPX_RESET;
            hs_prepare_timeout      <= HS_PREPARE_RESET;
            hs_exit_timeout         <= HS_EXIT_RESET;
            hs_go_timeout           <= HS_GO_RESET;
            hs_trail_timeout        <= HS_TRAIL_RESET;
            cmd_packet              <= '0;
        end else begin
            if (wr_en && bus.sel == REG_CR) begin
                packet_assembler_enable <= bus.wdata[CR_ASSEMBLER_BIT];
                lanes_enable            <= bus.wdata[CR_LANES_EN_BIT];
                clk_out_enable          <= bus.wdata[CR_CLK_EN_BIT];
                send_cmd                <= bus.wdata[CR_SEND_CMD_BIT];
                cr_lanes                <= bus.wdata[CR_LANES_LSB +: CR_LANES_WIDTH];
            end else if (lanes_active) begin
                send_cmd <= 1'b0;   // the command went out once the lanes are up.
            end
            if (wr_en && bus.sel == REG_IER) ier <= bus.wdata[IRQ_EVENTS-1:0];
            if (wr_en && bus.sel == REG_TR1) begin
                tlpx_timeout       <= bus.wdata[23:16];
                hs_prepare_timeout <= bus.wdata[15:8];
                hs_exit_timeout    <= bus.wdata[7:0];
            end
            if (wr_en && bus.sel == REG_TR2) begin
                hs_go_timeout    <= bus.wdata[15:8];
                hs_trail_timeout <= bus.wdata[7:0];
            end
            if (wr_en && bus.sel == REG_CMD) cmd_packet <= bus.wdata[CMD_WIDTH-1:0];
        end
    end

    // the flags themselves live in the interrupt controller.
    assign isr_clear = (wr_en && bus.sel == REG_ISR) ? bus.wdata[IRQ_EVENTS-1:0] : '0;

    // the field holds the lane count minus one.
    assign lanes_number = {1'b0, cr_lanes} + 1'b1;

    always_comb begin
        rd_mux = '0;   // reserved bits read as zero.
        case (bus.sel)
            REG_CR: begin
                rd_mux[CR_ASSEMBLER_BIT]                = packet_assembler_enable;
                rd_mux[CR_LANES_EN_BIT]                 = lanes_enable;
                rd_mux[CR_CLK_EN_BIT]                   = clk_out_enable;
                rd_mux[CR_SEND_CMD_BIT]                 = send_cmd;
                rd_mux[CR_LANES_LSB +: CR_LANES_WIDTH]  = cr_lanes;
            end
            REG_ISR: rd_mux[IRQ_EVENTS-1:0] = isr;
            REG_IER: rd_mux[IRQ_EVENTS-1:0] = ier;
            REG_TR1: rd_mux[23:0] = {tlpx_timeout, hs_prepare_timeout, hs_exit_timeout};
            REG_TR2: rd_mux[15:0] = {hs_go_timeout, hs_trail_timeout};
            REG_CMD: rd_mux[CMD_WIDTH-1:0] = cmd_packet;
            default: rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (access) bus.rdata <= rd_mux;
    end

    // ack comes up only while the master still holds its request.
    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(bus.ack) |-> bus.req
    );

endmodule

`default_nettype wire

// ==== rtl/avalon_mm_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

module avalon_mm_slave
    import dsi_regs_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic                  read,
    input  logic                  write,
    input  logic [DATA_WIDTH-1:0] writedata,
    output logic [DATA_WIDTH-1:0] readdata,
    output avl_resp_e             response,
    output logic                  waitrequest,
    reg_bus_if.master             bus
);

    slave_state_e          state;
    reg_idx_e              dec_sel;
    logic                  dec_err;
    reg_idx_e              sel_q;
    logic [DATA_WIDTH-1:0] wdata_q;
    logic                  write_q;
    logic                  err_q;
    logic                  start;

    assign start = read | write;   // the host holds these until waitrequest drops.

    always_comb begin
        dec_sel = REG_CR;
        dec_err = 1'b0;
        case (addr)
            REG_CR_OFFSET:  dec_sel = REG_CR;
            REG_ISR_OFFSET: dec_sel = REG_ISR;
            REG_IER_OFFSET: dec_sel = REG_IER;
            REG_TR1_OFFSET: dec_sel = REG_TR1;
            REG_TR2_OFFSET: dec_sel = REG_TR2;
            REG_CMD_OFFSET: dec_sel = REG_CMD;
            default:        dec_err = 1'b1;   // unaligned or beyond the map.
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            write_q <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        write_q <= write;
                        err_q   <= dec_err;
                        // an unmapped access never reaches the bank.
                        state   <= dec_err ? ST_DONE : ST_REQ;
                    end
                end
                ST_REQ:     if (bus.ack) state <= ST_RELEASE;
                ST_RELEASE: if (!bus.ack) state <= ST_DONE;
                default:    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            sel_q   <= dec_sel;
            wdata_q <= writedata;
        end
    end

    assign bus.req   = (state == ST_REQ);
    assign bus.sel   = sel_q;
    assign bus.write = write_q;
    assign bus.wdata = wdata_q;

    // The bank holds rdata until the next request, so it is still valid in ST_DONE.
    assign waitrequest = (state != ST_DONE);
    assign readdata    = (state == ST_DONE && !err_q && !write_q) ? bus.rdata : '0;
    assign response    = (state == ST_DONE && err_q) ? RESP_SLVERR : RESP_OKAY;

    // a new request must wait for the previous ack to fall.
    a_req_after_ack_low: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(bus.req) |-> !bus.ack
    );

    a_req_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        (bus.req && !bus.ack) |=> bus.req
    );

endmodule

`default_nettype wire

// ==== rtl/reg_bus_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// internal register access link, four-phase req/ack.
interface reg_bus_if
    import dsi_regs_pkg::*;
();

    reg_idx_e              sel;
    logic                  write;
    logic [DATA_WIDTH-1:0] wdata;
    logic                  req;
    logic                  ack;
    logic [DATA_WIDTH-1:0] rdata;

    modport master (
        output sel,
        output write,
        output wdata,
        output req,
        input  ack,
        input  rdata
    );

    modport slave (
        input  sel,
        input  write,
        input  wdata,
        input  req,
        output ack,
        output rdata
    );

endinterface

`default_nettype wire

// ==== rtl/dsi_regs_pkg.sv ====
`default_nettype none

package dsi_regs_pkg;

    localparam int DATA_WIDTH    = 32;
    localparam int ADDR_WIDTH    = 5;
    localparam int TIMEOUT_WIDTH = 8;
    localparam int CMD_WIDTH     = 24;
    localparam int IRQ_EVENTS    = 5;

    // one entry per register in the map.
    typedef enum logic [2:0] {
        REG_CR,
        REG_ISR,
        REG_IER,
        REG_TR1,
        REG_TR2,
        REG_CMD
    } reg_idx_e;

    localparam logic [ADDR_WIDTH-1:0] REG_CR_OFFSET  = 5'h00;
    localparam logic [ADDR_WIDTH-1:0] REG_ISR_OFFSET = 5'h04;
    localparam logic [ADDR_WIDTH-1:0] REG_IER_OFFSET = 5'h08;
    localparam logic [ADDR_WIDTH-1:0] REG_TR1_OFFSET = 5'h0C;
    localparam logic [ADDR_WIDTH-1:0] REG_TR2_OFFSET = 5'h10;
    localparam logic [ADDR_WIDTH-1:0] REG_CMD_OFFSET = 5'h14;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } avl_resp_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_RELEASE,
        ST_DONE
    } slave_state_e;

    // CR field positions.
    localparam int CR_ASSEMBLER_BIT = 0;
    localparam int CR_LANES_EN_BIT  = 1;
    localparam int CR_CLK_EN_BIT    = 2;
    localparam int CR_SEND_CMD_BIT  = 3;
    localparam int CR_LANES_LSB     = 8;
    localparam int CR_LANES_WIDTH   = 2;

    // Bit order of the events, the same in ISR and IER.
    typedef enum logic [2:0] {
        EV_PIX_UNDERFLOW  = 3'd0,
        EV_LANES_READY    = 3'd1,
        EV_CLK_READY      = 3'd2,
        EV_LANES_ACTIVE   = 3'd3,
        EV_LANES_INACTIVE = 3'd4
    } irq_bit_e;

endpackage

`default_nettype wire
